// File: src/mem_cfg_pkg.sv
//==========================================================
// sizing constants for the memory-request front end
// bus widths, channel count, queue depths, address map
//==========================================================

`default_nettype none

package mem_cfg_pkg;

	// cpu bus
	localparam int addr_w = 16;
	localparam int data_w = 8;

	// channels and the address map
	localparam int num_chan = 4;
	localparam int chan_w = $clog2(num_chan);
	// addr[15:14] picks the channel
	localparam int chan_sel_lsb = 14;
	// addr[9:0] is the store offset, addr[13:10] aliases
	localparam int ofs_w = 10;

	// queueing
	localparam int track_depth = 4;
	localparam int track_ptr_w = $clog2(track_depth);
	localparam int inbox_depth = 2;
	localparam int inbox_ptr_w = $clog2(inbox_depth);

	// a tracker holds one credit per inbox slot
	localparam int credit_w = $clog2(inbox_depth + 1);

endpackage

`default_nettype wire

// File: src/mem_types_pkg.sv
//==========================================================
// channel and opcode enums
// packed cpu bus, channel view, request and response
//==========================================================

`default_nettype none

package mem_types_pkg;

	// numbered in address order, addr[15:14]
	typedef enum logic [mem_cfg_pkg::chan_w-1:0] {
		chan_wram  = 2'd0,
		chan_aram  = 2'd1,
		chan_vram  = 2'd2,
		chan_bsram = 2'd3
	} chan_e;

	typedef enum logic {
		op_read  = 1'b0,
		op_write = 1'b1
	} op_e;

	// raw cpu bus, 27 bits
	typedef struct packed {
		logic                            sel;
		logic                            rd;
		logic                            wr;
		logic [mem_cfg_pkg::addr_w-1:0] addr;
		logic [mem_cfg_pkg::data_w-1:0] wdata;
	} cpu_bus_t;

	// one channel's view after decode, 20 bits
	typedef struct packed {
		logic                           act_rd;
		logic                           act_wr;
		logic [mem_cfg_pkg::ofs_w-1:0]  ofs;
		logic [mem_cfg_pkg::data_w-1:0] wdata;
	} chan_bus_t;

	// queued access, 19 bits
	typedef struct packed {
		op_e                            op;
		logic [mem_cfg_pkg::ofs_w-1:0]  ofs;
		logic [mem_cfg_pkg::data_w-1:0] wdata;
	} mem_req_t;

	// read response, 21 bits
	typedef struct packed {
		logic                           valid;
		chan_e                          chan;
		logic [mem_cfg_pkg::ofs_w-1:0]  ofs;
		logic [mem_cfg_pkg::data_w-1:0] rdata;
	} mem_rsp_t;

endpackage

`default_nettype wire

// File: src/bus_decoder.sv
//==========================================================
// cpu bus decoder
// one channel view per select value, plus the local offset
//==========================================================

`timescale 1ns/1ns
`default_nettype none

module bus_decoder (
	input  mem_types_pkg::cpu_bus_t                              bus,
	output mem_types_pkg::chan_bus_t [mem_cfg_pkg::num_chan-1:0] chan
);

	import mem_cfg_pkg::*;
	import mem_types_pkg::*;

	logic [num_chan-1:0] hit;

	// select bits compared against each channel number
	always_comb begin
		for (int i = 0; i < num_chan; i++) begin
			hit[i] = bus.sel && (bus.addr[chan_sel_lsb +: chan_w] == chan_w'(i));
		end
	end

	always_comb begin
		for (int i = 0; i < num_chan; i++) begin
			chan[i].act_rd = hit[i] & bus.rd;
			chan[i].act_wr = hit[i] & bus.wr;
			// bits 13:10 dropped here, so addresses alias
			chan[i].ofs    = bus.addr[ofs_w-1:0];
			chan[i].wdata  = bus.wdata;
		end
	end

endmodule

`default_nettype wire

// File: src/channel_tracker.sv
//==========================================================
// per-channel access tracker
// event detection, request queue, credit counter
//==========================================================

`timescale 1ns/1ns
`default_nettype none

module channel_tracker (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  mem_types_pkg::chan_bus_t cbus,
	output logic                     stall,
	input  logic                     credit_ret,
	output logic                     req_valid,
	output mem_types_pkg::mem_req_t  req
);

	import mem_cfg_pkg::*;
	import mem_types_pkg::*;

	logic                   rd_d;
	logic                   wr_d;
	logic [ofs_w-1:0]       last_rd_ofs;
	logic                   rd_evt;
	logic                   wr_evt;
	logic                   push;
	logic                   send;
	mem_req_t               new_req;
	mem_req_t               q [track_depth];
	logic [track_ptr_w-1:0] wr_ptr;
	logic [track_ptr_w-1:0] rd_ptr;
	logic [track_ptr_w:0]   count;
	logic [credit_w-1:0]    credits;

	//==========================================================
	// event rule
	//==========================================================

	// a held read counts again each time the offset moves
	assign rd_evt = cbus.act_rd && (!rd_d || cbus.ofs != last_rd_ofs);
	assign wr_evt = cbus.act_wr && !wr_d;

	// read and write together is not a legal bus cycle, write wins
	always_comb begin
		new_req.op    = wr_evt ? op_write : op_read;
		new_req.ofs   = cbus.ofs;
		new_req.wdata = cbus.wdata;
	end

	assign stall = (count == (track_ptr_w + 1)'(track_depth));
	// events arriving while full are dropped
	assign push  = (rd_evt | wr_evt) & ~stall;

	//==========================================================
	// queue and credits
	//==========================================================

	assign req_valid = (count != '0) && (credits != '0);
	assign send      = req_valid;
	assign req       = q[rd_ptr];

	always_ff @(posedge clk_sys) begin
		if (push) begin
			q[wr_ptr] <= new_req;
		end
		if (rd_evt) begin
			last_rd_ofs <= cbus.ofs;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_d    <= 1'b0;
			wr_d    <= 1'b0;
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			credits <= credit_w'(inbox_depth);
		end else begin
			rd_d <= cbus.act_rd;
			wr_d <= cbus.act_wr;
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (send) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count   <= count + {{track_ptr_w{1'b0}}, push}
				- {{track_ptr_w{1'b0}}, send};
			// one spent per send, one back per inbox pop
			credits <= credits - {{(credit_w-1){1'b0}}, send}
				+ {{(credit_w-1){1'b0}}, credit_ret};
		end
	end

endmodule

`default_nettype wire

// File: src/access_scheduler.sv
//==========================================================
// round-robin access scheduler
// per-channel inboxes, grant, credit return, read response
//==========================================================

`timescale 1ns/1ns
`default_nettype none

module access_scheduler (
	input  logic                                                clk_sys,
	input  logic                                                reset,
	input  logic [mem_cfg_pkg::num_chan-1:0]                    req_valid,
	input  mem_types_pkg::mem_req_t [mem_cfg_pkg::num_chan-1:0] req,
	output logic [mem_cfg_pkg::num_chan-1:0]                    credit_ret,
	output logic                                                st_rd,
	output logic                                                st_wr,
	output mem_types_pkg::chan_e                                st_chan,
	output logic [mem_cfg_pkg::ofs_w-1:0]                       st_ofs,
	output logic [mem_cfg_pkg::data_w-1:0]                      st_wdata,
	input  logic [mem_cfg_pkg::data_w-1:0]                      st_rdata,
	output mem_types_pkg::mem_rsp_t                             rsp
);

	import mem_cfg_pkg::*;
	import mem_types_pkg::*;

	mem_req_t               inbox [num_chan][inbox_depth];
	logic [inbox_ptr_w-1:0] ib_wr [num_chan];
	logic [inbox_ptr_w-1:0] ib_rd [num_chan];
	logic [inbox_ptr_w:0]   ib_cnt [num_chan];
	logic [num_chan-1:0]    ready;
	logic [chan_w-1:0]      last_gnt;
	logic [chan_w-1:0]      gnt_chan;
	logic                   gnt_any;
	mem_req_t               head;
	logic                   rsp_valid;
	chan_e                  rsp_chan;
	logic [ofs_w-1:0]       rsp_ofs;

	always_comb begin
		for (int i = 0; i < num_chan; i++) begin
			ready[i] = (ib_cnt[i] != '0);
		end
	end

	// search starts at the channel after the last grant
	always_comb begin : rr_pick
		logic [chan_w-1:0] idx;
		gnt_any  = 1'b0;
		gnt_chan = last_gnt;
		for (int k = 1; k <= num_chan; k++) begin
			idx = last_gnt + chan_w'(k);
			if (!gnt_any && ready[idx]) begin
				gnt_any  = 1'b1;
				gnt_chan = idx;
			end
		end
	end

	assign head       = inbox[gnt_chan][ib_rd[gnt_chan]];
	assign credit_ret = gnt_any ? (num_chan'(1) << gnt_chan) : '0;

	assign st_rd    = gnt_any && (head.op == op_read);
	assign st_wr    = gnt_any && (head.op == op_write);
	assign st_chan  = chan_e'(gnt_chan);
	assign st_ofs   = head.ofs;
	assign st_wdata = head.wdata;

	always_ff @(posedge clk_sys) begin
		for (int i = 0; i < num_chan; i++) begin
			if (req_valid[i]) begin
				inbox[i][ib_wr[i]] <= req[i];
			end
		end
		// tag for the read in flight
		if (st_rd) begin
			rsp_chan <= st_chan;
			rsp_ofs  <= st_ofs;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			for (int i = 0; i < num_chan; i++) begin
				ib_wr[i]  <= '0;
				ib_rd[i]  <= '0;
				ib_cnt[i] <= '0;
			end
			last_gnt  <= '0;
			rsp_valid <= 1'b0;
		end else begin
			for (int i = 0; i < num_chan; i++) begin
				if (req_valid[i]) begin
					ib_wr[i] <= ib_wr[i] + 1'b1;
				end
				if (credit_ret[i]) begin
					ib_rd[i] <= ib_rd[i] + 1'b1;
				end
				ib_cnt[i] <= ib_cnt[i] + {{inbox_ptr_w{1'b0}}, req_valid[i]}
					- {{inbox_ptr_w{1'b0}}, credit_ret[i]};
			end
			if (gnt_any) begin
				last_gnt <= gnt_chan;
			end
			rsp_valid <= st_rd;
		end
	end

	// store data lands one cycle after the grant
	always_comb begin
		rsp.valid = rsp_valid;
		rsp.chan  = rsp_chan;
		rsp.ofs   = rsp_ofs;
		rsp.rdata = st_rdata;
	end

endmodule

`default_nettype wire

// File: src/shared_store.sv
//==========================================================
// shared byte store, one region per channel
// write at the grant edge, registered read
//==========================================================

`timescale 1ns/1ns
`default_nettype none

module shared_store (
	input  logic                           clk_sys,
	input  logic                           rd_en,
	input  logic                           wr_en,
	input  mem_types_pkg::chan_e           chan,
	input  logic [mem_cfg_pkg::ofs_w-1:0]  ofs,
	input  logic [mem_cfg_pkg::data_w-1:0] wdata,
	output logic [mem_cfg_pkg::data_w-1:0] rdata
);

	import mem_cfg_pkg::*;
	import mem_types_pkg::*;

	logic [data_w-1:0]       mem [num_chan * (2 ** ofs_w)];
	logic [chan_w+ofs_w-1:0] addr;

	// channel in the upper bits keeps the regions apart
	assign addr = {chan, ofs};

	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			mem[addr] <= wdata;
		end
		if (rd_en) begin
			rdata <= mem[addr];
		end
	end

endmodule

`default_nettype wire

// File: src/memport_top.sv
//==========================================================
// memory-request front end, top level
// decoder, four trackers, scheduler, shared store
//==========================================================

`timescale 1ns/1ns
`default_nettype none

module memport_top (
	input  logic                             clk_sys,
	input  logic                             reset,
	input  mem_types_pkg::cpu_bus_t          bus,
	output logic [mem_cfg_pkg::num_chan-1:0] stall,
	output mem_types_pkg::mem_rsp_t          rsp
);

	import mem_cfg_pkg::*;
	import mem_types_pkg::*;

	chan_bus_t [num_chan-1:0] cbus;
	logic [num_chan-1:0]      req_valid;
	mem_req_t [num_chan-1:0]  req;
	logic [num_chan-1:0]      credit_ret;
	logic                     st_rd;
	logic                     st_wr;
	chan_e                    st_chan;
	logic [ofs_w-1:0]         st_ofs;
	logic [data_w-1:0]        st_wdata;
	logic [data_w-1:0]        st_rdata;

	bus_decoder u_decoder (
		.bus  (bus),
		.chan (cbus)
	);

	// one tracker per channel, same logic for all four
	for (genvar g = 0; g < num_chan; g++) begin : g_trk
		channel_tracker u_tracker (
			.clk_sys    (clk_sys),
			.reset      (reset),
			.cbus       (cbus[g]),
			.stall      (stall[g]),
			.credit_ret (credit_ret[g]),
			.req_valid  (req_valid[g]),
			.req        (req[g])
		);
	end

	access_scheduler u_scheduler (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.req_valid  (req_valid),
		.req        (req),
		.credit_ret (credit_ret),
		.st_rd      (st_rd),
		.st_wr      (st_wr),
		.st_chan    (st_chan),
		.st_ofs     (st_ofs),
		.st_wdata   (st_wdata),
		.st_rdata   (st_rdata),
		.rsp        (rsp)
	);

	shared_store u_store (
		.clk_sys (clk_sys),
		.rd_en   (st_rd),
		.wr_en   (st_wr),
		.chan    (st_chan),
		.ofs     (st_ofs),
		.wdata   (st_wdata),
		.rdata   (st_rdata)
	);

endmodule

`default_nettype wire

// File: verification/memport_assertions.sv
//==========================================================
// protocol assertions for the memory-request front end
// credit bounds, read-to-response timing, stall rule
//==========================================================

`timescale 1ns/1ns
`default_nettype none

module memport_assertions (
	input logic                                                 clk_sys,
	input logic                                                 reset,
	input mem_types_pkg::chan_bus_t [mem_cfg_pkg::num_chan-1:0] cbus,
	input logic [mem_cfg_pkg::num_chan-1:0]                     stall,
	input logic [mem_cfg_pkg::num_chan-1:0]                     req_valid,
	input logic [mem_cfg_pkg::num_chan-1:0]                     credit_ret,
	input logic                                                 st_rd,
	input mem_types_pkg::mem_rsp_t                              rsp
);

	import mem_cfg_pkg::*;
	import mem_types_pkg::*;

	// one extra bit so an overflow stays visible
	logic [credit_w:0]   cred [num_chan];
	logic [num_chan-1:0] rd_q;
	logic [num_chan-1:0] wr_q;
	logic [ofs_w-1:0]    ofs_q [num_chan];
	logic [num_chan-1:0] starts;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			for (int i = 0; i < num_chan; i++) begin
				cred[i] <= (credit_w + 1)'(inbox_depth);
			end
			rd_q <= '0;
			wr_q <= '0;
		end else begin
			for (int i = 0; i < num_chan; i++) begin
				cred[i] <= cred[i] - {{credit_w{1'b0}}, req_valid[i]}
					+ {{credit_w{1'b0}}, credit_ret[i]};
				rd_q[i] <= cbus[i].act_rd;
				wr_q[i] <= cbus[i].act_wr;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		for (int i = 0; i < num_chan; i++) begin
			ofs_q[i] <= cbus[i].ofs;
		end
	end

	// new read, moved held read, or new write
	always_comb begin
		for (int i = 0; i < num_chan; i++) begin
			starts[i] = (cbus[i].act_rd && (!rd_q[i] || cbus[i].ofs != ofs_q[i]))
				|| (cbus[i].act_wr && !wr_q[i]);
		end
	end

	for (genvar g = 0; g < num_chan; g++) begin : g_chk
		a_send_credit: assert property (@(posedge clk_sys) disable iff (reset)
			req_valid[g] |-> cred[g] != '0)
			else $error("channel %0d sent a request with no credit", g);

		a_credit_max: assert property (@(posedge clk_sys) disable iff (reset)
			cred[g] <= (credit_w + 1)'(inbox_depth))
			else $error("channel %0d holds more credits than inbox slots", g);

		a_stalled_start: assert property (@(posedge clk_sys) disable iff (reset)
			starts[g] |-> !stall[g])
			else $error("access started on stalled channel %0d", g);
	end

	a_rsp_after_rd: assert property (@(posedge clk_sys) disable iff (reset)
		st_rd |=> rsp.valid)
		else $error("read grant not followed by a response");

	a_rsp_needs_rd: assert property (@(posedge clk_sys) disable iff (reset)
		rsp.valid |-> $past(st_rd))
		else $error("response without a read grant one cycle before");

endmodule

bind memport_top memport_assertions u_assertions (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.cbus       (cbus),
	.stall      (stall),
	.req_valid  (req_valid),
	.credit_ret (credit_ret),
	.st_rd      (st_rd),
	.rsp        (rsp)
);

`default_nettype wire

// File: verification/memport_tb.sv
//==========================================================
// testbench for memport_top
// clock and reset, directed and random bus traffic,
// reference model and response checker
//==========================================================

`timescale 1ns/1ns
`default_nettype none

module memport_tb;

	import mem_cfg_pkg::*;
	import mem_types_pkg::*;

	typedef struct packed {
		logic              known;
		logic [ofs_w-1:0]  ofs;
		logic [data_w-1:0] rdata;
	} exp_t;

	localparam int n_rand = 300;
	localparam int burst_len = 16;
	// reset, idle, write/read, held reads, held write, isolation, random, burst, drain
	localparam int stim_cycles = 8 + 20 + 16 + 23 + 8 + 12 + 2 * n_rand + burst_len + 40;
	localparam int cycle_limit = 4 * stim_cycles + 200;

	logic                clk_sys;
	logic                reset;
	cpu_bus_t            bus;
	logic [num_chan-1:0] stall;
	mem_rsp_t            rsp;

	cpu_bus_t          prev_bus;
	logic [data_w-1:0] model_mem [num_chan][2 ** ofs_w];
	bit                written [num_chan][2 ** ofs_w];
	exp_t              exp_q [num_chan][$];
	int                cycles;
	int                seed;

	memport_top u_dut (
		.clk_sys (clk_sys),
		.reset   (reset),
		.bus     (bus),
		.stall   (stall),
		.rsp     (rsp)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	function automatic cpu_bus_t make_bus(input logic rd, input logic wr,
			input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
		cpu_bus_t b;
		b.sel   = rd | wr;
		b.rd    = rd;
		b.wr    = wr;
		b.addr  = addr;
		b.wdata = data;
		return b;
	endfunction

	//==========================================================
	// reference model
	//==========================================================

	// event seen by channel ch when the bus goes from prev to cur
	function automatic logic ref_event(input cpu_bus_t prev, input cpu_bus_t cur,
			input int ch, output mem_req_t evt);
		logic prev_rd;
		logic prev_wr;
		logic cur_rd;
		logic cur_wr;
		prev_rd = prev.sel && prev.rd && (prev.addr[15:14] == 2'(ch));
		prev_wr = prev.sel && prev.wr && (prev.addr[15:14] == 2'(ch));
		cur_rd  = cur.sel && cur.rd && (cur.addr[15:14] == 2'(ch));
		cur_wr  = cur.sel && cur.wr && (cur.addr[15:14] == 2'(ch));
		evt       = '0;
		evt.ofs   = cur.addr[9:0];
		evt.wdata = cur.wdata;
		if (cur_wr && !prev_wr) begin
			evt.op = op_write;
			return 1'b1;
		end
		evt.op = op_read;
		return cur_rd && (!prev_rd || cur.addr[9:0] != prev.addr[9:0]);
	endfunction

	task automatic apply_bus(input cpu_bus_t b);
		mem_req_t evt;
		exp_t     e;
		for (int ch = 0; ch < num_chan; ch++) begin
			if (ref_event(prev_bus, b, ch, evt)) begin
				if (evt.op == op_write) begin
					model_mem[ch][evt.ofs] = evt.wdata;
					written[ch][evt.ofs]   = 1'b1;
				end else begin
					e.known = written[ch][evt.ofs];
					e.ofs   = evt.ofs;
					e.rdata = model_mem[ch][evt.ofs];
					exp_q[ch].push_back(e);
				end
			end
		end
		bus      = b;
		prev_bus = b;
	endtask

	function automatic int pending_count();
		int n;
		n = 0;
		for (int ch = 0; ch < num_chan; ch++) begin
			n += exp_q[ch].size();
		end
		return n;
	endfunction

	//==========================================================
	// stimulus helpers
	//==========================================================

	task automatic drive_cycle(input cpu_bus_t b);
		@(posedge clk_sys);
		#1;
		apply_bus(b);
	endtask

	// waits out a stall, then one access cycle and one idle cycle
	task automatic single_access(input op_e op, input logic [addr_w-1:0] addr,
			input logic [data_w-1:0] data);
		int ch;
		ch = int'(addr[15:14]);
		@(posedge clk_sys);
		#1;
		while (stall[ch]) begin
			apply_bus('0);
			@(posedge clk_sys);
			#1;
		end
		apply_bus(make_bus(op == op_read, op == op_write, addr, data));
		drive_cycle('0);
	endtask

	task automatic idle_check();
		repeat (20) begin
			drive_cycle('0);
			assert (!rsp.valid && stall == '0)
			else report_error("response or stall seen while the bus is idle");
		end
	endtask

	task automatic write_then_read();
		logic [addr_w-1:0] addr;
		for (int ch = 0; ch < num_chan; ch++) begin
			addr = {2'(ch), 4'h0, 10'(16 * ch + 3)};
			single_access(op_write, addr, 8'(8'hc0 + ch));
			single_access(op_read, addr, '0);
		end
	endtask

	task automatic held_reads();
		for (int i = 0; i < 5; i++) begin
			single_access(op_write, 16'h8100 + 16'(i), 8'(8'h40 + i));
		end
		// one response only, however long the read is held
		repeat (6) drive_cycle(make_bus(1'b1, 1'b0, 16'h8102, '0));
		drive_cycle('0);
		// one response per new offset
		for (int i = 0; i < 5; i++) begin
			drive_cycle(make_bus(1'b1, 1'b0, 16'h8100 + 16'(i), '0));
		end
		drive_cycle('0);
	endtask

	task automatic held_write();
		for (int i = 0; i < 5; i++) begin
			drive_cycle(make_bus(1'b0, 1'b1, 16'h4200, 8'(8'h30 + i)));
		end
		drive_cycle('0);
		single_access(op_read, 16'h4200, '0);
	endtask

	task automatic isolation_and_alias();
		single_access(op_write, 16'h0055, 8'ha5);
		single_access(op_write, 16'h8055, 8'h5a);
		single_access(op_read, 16'h0055, '0);
		single_access(op_read, 16'h8055, '0);
		// bits 13:10 differ, same byte expected
		single_access(op_write, 16'h4123, 8'h77);
		single_access(op_read, 16'h4000 | (16'd5 << 10) | 16'h0123, '0);
	endtask

	task automatic random_traffic();
		logic [31:0]       r;
		logic [addr_w-1:0] addr;
		for (int i = 0; i < n_rand; i++) begin
			r = $random(seed);
			// sixteen offsets per channel, random alias bits
			addr = {r[1:0], r[5:2], 6'b0, r[9:6]};
			if (r[10]) begin
				single_access(op_write, addr, r[18:11]);
			end else begin
				single_access(op_read, addr, '0);
			end
		end
	endtask

	// held read stepping its offset every cycle, paused while stalled
	task automatic burst_one_channel();
		for (int i = 0; i < burst_len; i++) begin
			@(posedge clk_sys);
			#1;
			if (stall[3]) begin
				apply_bus('0);
			end else begin
				apply_bus(make_bus(1'b1, 1'b0, 16'hc000 + 16'(i), '0));
			end
		end
		drive_cycle('0);
	endtask

	//==========================================================
	// response checker
	//==========================================================

	task automatic check_response();
		exp_t e;
		int   ch;
		ch = int'(rsp.chan);
		assert (exp_q[ch].size() != 0)
		else report_error($sformatf("unexpected response on channel %0d at %0t", ch, $time));
		if (exp_q[ch].size() != 0) begin
			e = exp_q[ch].pop_front();
			assert (rsp.ofs === e.ofs)
			else report_error($sformatf("Mismatch at %0t: rsp.ofs = %h, expected %h",
				$time, rsp.ofs, e.ofs));
			if (e.known) begin
				assert (rsp.rdata === e.rdata)
				else report_error($sformatf("Mismatch at %0t: rsp.rdata = %h, expected %h",
					$time, rsp.rdata, e.rdata));
			end
		end
	endtask

	// outputs change at the rising edge, so look at the falling one
	always @(negedge clk_sys) begin
		if (!reset && rsp.valid === 1'b1) begin
			check_response();
		end
	end

	initial begin : watchdog
		cycles = 0;
		forever begin
			@(posedge clk_sys);
			cycles++;
			if (cycles > cycle_limit) begin
				report_error("timeout, responses still missing at the cycle limit");
			end
		end
	end

	initial begin : stimulus
		seed     = 32'heac55033;
		reset    = 1'b1;
		bus      = '0;
		prev_bus = '0;
		repeat (8) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		idle_check();
		write_then_read();
		held_reads();
		held_write();
		isolation_and_alias();
		random_traffic();
		burst_one_channel();

		while (pending_count() != 0) begin
			drive_cycle('0);
		end
		// any late extra response is caught here
		repeat (20) drive_cycle('0);

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: memport_top.f
src/mem_cfg_pkg.sv
src/mem_types_pkg.sv
src/bus_decoder.sv
src/channel_tracker.sv
src/access_scheduler.sv
src/shared_store.sv
src/memport_top.sv
verification/memport_assertions.sv
verification/memport_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the memport testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module memport_tb -f memport_top.f -o Vmemport_tb

status=0
./obj_dir/Vmemport_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi
echo "simulation finished cleanly"
